/* verilog.f */
design/wb_pkg.sv
design/line_bus_if.sv
design/write_buffer.sv
design/refill_reader.sv
design/bus_arbiter.sv
design/line_memory.sv
design/wb_subsystem.sv
test/tb_wb_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_wb_subsystem \
    -f verilog.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi

/* test/tb_wb_subsystem.sv */
module tb_wb_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 5;
    localparam int MEM_LINES = 16;
    localparam int RAND_ITERS = 120;
    // a drain burst takes about 12 cycles, so this leaves plenty of slack
    localparam int DRAIN_CYCLES = DEPTH * 24 + 40;
    localparam int WATCH_OPS = MEM_LINES * 3 + RAND_ITERS * 3 + DEPTH + 2;
    localparam int WATCH_CYCLES = WATCH_OPS * 40 + DRAIN_CYCLES * 2 + 200;

    logic               clk;
    logic               rstn;
    wb_pkg::line_addr_u in_addr;
    wb_pkg::line_t      in_data;
    logic               in_valid;
    logic               in_ready;
    wb_pkg::line_addr_u rd_addr;
    logic               rd_valid;
    logic               rd_ready;
    wb_pkg::line_t      rsp_data;
    logic               rsp_hit;
    logic               rsp_valid;
    logic               rsp_ready;

    logic [31:0]   seed = 32'h23da_67f3;
    wb_pkg::line_t model [int];
    int            mismatches = 0;
    int            failures = 0;
    int            n_req = 0;
    int            n_rsp = 0;
    logic          saw_full = 1'b0;
    logic          stall_prev = 1'b0;
    wb_pkg::line_t held_data;

    wb_subsystem #(
        .DEPTH(DEPTH),
        .MEM_LINES(MEM_LINES)
    ) UUT (
        .clk      (clk),
        .rstn     (rstn),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rsp_data (rsp_data),
        .rsp_hit  (rsp_hit),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // low lcg bits repeat quickly, so take the index from the middle
    function automatic int rand_index();
        logic [31:0] r;
        r = next_rand();
        return int'(r[23:8]) % MEM_LINES;
    endfunction

    function automatic wb_pkg::line_t rand_line();
        wb_pkg::line_t l;
        for (int w = 0; w < wb_pkg::LINE_WORDS_MAX; w++) begin
            l[w*32 +: 32] = next_rand();
        end
        return l;
    endfunction

    function automatic wb_pkg::line_addr_u line_addr(input int idx);
        wb_pkg::line_addr_u a;
        a.raw = '0;
        a.f.index = idx[wb_pkg::INDEX_BITS-1:0];
        return a;
    endfunction

    // never-written lines read as zero
    function automatic wb_pkg::line_t expected_line(input int idx);
        if (model.exists(idx)) begin
            return model[idx];
        end
        return '0;
    endfunction

    task automatic check_line(input string name, input wb_pkg::line_t exp,
                              input wb_pkg::line_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0d ns: %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    // every task starts and ends 2 ns after a rising edge
    task automatic do_insert(input int idx, input wb_pkg::line_t data);
        in_addr = line_addr(idx);
        in_data = data;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            saw_full = 1'b1;
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        model[idx] = data;
    endtask

    task automatic do_read(input int idx, input bit check_hit, input bit exp_hit);
        wb_pkg::line_t exp;
        logic [31:0]   r;
        exp = expected_line(idx);
        rd_addr = line_addr(idx);
        rd_valid = 1'b1;
        @(negedge clk);
        while (!rd_ready) begin
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        rd_valid = 1'b0;
        n_req++;
        r = next_rand();
        rsp_ready = r[17:16] != 2'b00;
        @(negedge clk);
        while (!(rsp_valid && rsp_ready)) begin
            @(posedge clk);
            #2;
            r = next_rand();
            rsp_ready = r[17:16] != 2'b00;
            @(negedge clk);
        end
        // request still held until this handshake
        check_flag("rd_ready", 1'b0, rd_ready);
        check_line("rsp_data", exp, rsp_data);
        if (check_hit) begin
            check_flag("rsp_hit", exp_hit, rsp_hit);
        end
        @(posedge clk);
        #2;
        rsp_ready = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (!in_ready) begin
            @(posedge clk);
            #2;
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        #2;
    endtask

    task automatic read_all_lines();
        for (int i = 0; i < MEM_LINES; i++) begin
            do_read(i, 1'b1, 1'b0);
        end
    endtask

    // response must hold still while stalled
    always @(negedge clk) begin
        if (rstn) begin
            if (stall_prev) begin
                if (!rsp_valid) begin
                    failures++;
                    $display("error at %0d ns: rsp_valid dropped before rsp_ready", $time);
                end
                check_line("rsp_data held", held_data, rsp_data);
            end
            if (rsp_valid && rsp_ready) begin
                n_rsp++;
            end
            stall_prev = rsp_valid && !rsp_ready;
            held_data = rsp_data;
        end
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          idx;
        logic [31:0] r;
        rstn = 1'b0;
        in_addr = '0;
        in_data = '0;
        in_valid = 1'b0;
        rd_addr = '0;
        rd_valid = 1'b0;
        rsp_ready = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;

        // memory starts cleared
        read_all_lines();

        for (int it = 0; it < RAND_ITERS; it++) begin
            r = next_rand();
            idx = rand_index();
            case (r[13:12])
                2'd0: do_insert(idx, rand_line());
                2'd1: begin
                    do_insert(idx, rand_line());
                    do_read(idx, 1'b1, 1'b1);
                end
                2'd2: do_read(idx, 1'b0, 1'b0);
                default: begin
                    do_insert(idx, rand_line());
                    do_insert(idx, rand_line());
                    do_read(idx, 1'b1, 1'b1);
                end
            endcase
        end

        wait_drain();
        read_all_lines();

        // back-to-back inserts past capacity
        saw_full = 1'b0;
        repeat (DEPTH + 2) do_insert(rand_index(), rand_line());
        check_flag("in_ready low when full", 1'b1, saw_full);
        wait_drain();
        read_all_lines();

        if (n_rsp != n_req) begin
            failures++;
            $display("error: %0d read requests got %0d responses", n_req, n_rsp);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* design/wb_subsystem.sv */
module wb_subsystem #(
    parameter int DEPTH = 5,
    parameter int MEM_LINES = 16
) (
    input  logic               clk,
    input  logic               rstn,
    input  wb_pkg::line_addr_u in_addr,
    input  wb_pkg::line_t      in_data,
    input  logic               in_valid,
    output logic               in_ready,
    input  wb_pkg::line_addr_u rd_addr,
    input  logic               rd_valid,
    output logic               rd_ready,
    output wb_pkg::line_t      rsp_data,
    output logic               rsp_hit,
    output logic               rsp_valid,
    input  logic               rsp_ready
);

    wb_pkg::line_addr_u query_addr;
    wb_pkg::line_t      query_data;
    logic               query_hit;

    line_bus_if wb_bus ();
    line_bus_if rr_bus ();
    line_bus_if mem_bus ();

    write_buffer #(
        .DEPTH(DEPTH)
    ) u_write_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .in_addr   (in_addr),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .query_addr(query_addr),
        .query_data(query_data),
        .query_hit (query_hit),
        .bus       (wb_bus.master)
    );

    refill_reader u_refill_reader (
        .clk       (clk),
        .rstn      (rstn),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rsp_data  (rsp_data),
        .rsp_hit   (rsp_hit),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .query_addr(query_addr),
        .query_data(query_data),
        .query_hit (query_hit),
        .bus       (rr_bus.master)
    );

    // drain on m0, refill on m1
    bus_arbiter u_bus_arbiter (
        .clk (clk),
        .rstn(rstn),
        .m0  (wb_bus.slave),
        .m1  (rr_bus.slave),
        .mem (mem_bus.master)
    );

    line_memory #(
        .MEM_LINES(MEM_LINES)
    ) u_line_memory (
        .clk (clk),
        .rstn(rstn),
        .bus (mem_bus.slave)
    );

endmodule

/* design/line_memory.sv */
module line_memory #(
    parameter int MEM_LINES = 16
) (
    input  logic      clk,
    input  logic      rstn,
    line_bus_if.slave bus
);

    localparam int BEAT_BITS = $clog2(wb_pkg::LINE_WORDS_MAX);
    localparam int LINE_BITS = $clog2(MEM_LINES);
    localparam int WORDS = MEM_LINES * wb_pkg::LINE_WORDS_MAX;
    localparam int AW = LINE_BITS + BEAT_BITS;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_WRITE = 2'd1;
    localparam logic [1:0] S_READ  = 2'd2;

    wb_pkg::word_t mem_q [WORDS];

    logic [1:0]           state;
    logic                 sweeping;
    logic [AW-1:0]        sweep_idx;
    logic [LINE_BITS-1:0] line_q;
    logic [BEAT_BITS-1:0] beat;
    logic [AW-1:0]        word_idx;
    logic                 wr_en;
    logic [AW-1:0]        wr_idx;
    wb_pkg::word_t        wr_word;

    assign word_idx = {line_q, beat};

    // zero sweep shares the write port
    always_comb begin
        wr_en = sweeping || (bus.wvalid && bus.wready);
        wr_idx = sweeping ? sweep_idx : word_idx;
        wr_word = sweeping ? '0 : bus.wdata;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_idx] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
            sweeping <= 1'b1;
            sweep_idx <= '0;
            beat <= '0;
        end else begin
            if (sweeping) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == AW'(WORDS - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            case (state)
                S_IDLE: begin
                    if (bus.req && bus.gnt_ack) begin
                        state <= bus.we ? S_WRITE : S_READ;
                        beat <= '0;
                    end
                end
                S_WRITE: begin
                    if (bus.wvalid) begin
                        beat <= beat + 1'b1;
                        if (bus.wlast) begin
                            state <= S_IDLE;
                        end
                    end
                end
                S_READ: begin
                    // hold the beat while the master stalls
                    if (bus.rready) begin
                        beat <= beat + 1'b1;
                        if (bus.rlast) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req && bus.gnt_ack) begin
            line_q <= bus.addr.f.index[LINE_BITS-1:0];
        end
    end

    assign bus.gnt_ack = state == S_IDLE && !sweeping;
    assign bus.wready = state == S_WRITE;
    assign bus.rvalid = state == S_READ;
    assign bus.rdata = mem_q[word_idx];
    assign bus.rlast = beat == BEAT_BITS'(wb_pkg::LINE_WORDS_MAX - 1);

endmodule

/* design/bus_arbiter.sv */
module bus_arbiter (
    input  logic       clk,
    input  logic       rstn,
    line_bus_if.slave  m0,
    line_bus_if.slave  m1,
    line_bus_if.master mem
);

    logic locked;
    logic owner;
    logic prio;
    logic pick;
    logic burst_end;

    // prio set means m1 wins a tie
    assign pick = m1.req && (!m0.req || prio);
    assign burst_end = (mem.wvalid && mem.wready && mem.wlast) ||
                       (mem.rvalid && mem.rready && mem.rlast);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            locked <= 1'b0;
            owner <= 1'b0;
            prio <= 1'b0;
        end else if (!locked) begin
            if (m0.req || m1.req) begin
                locked <= 1'b1;
                owner <= pick;
                prio <= !pick;
            end
        end else if (burst_end) begin
            locked <= 1'b0;
        end
    end

    // read data is shared, handshakes only reach the owner
    assign m0.rdata = mem.rdata;
    assign m0.rlast = mem.rlast;
    assign m1.rdata = mem.rdata;
    assign m1.rlast = mem.rlast;

    always_comb begin
        mem.req = 1'b0;
        mem.we = 1'b0;
        mem.addr = '0;
        mem.wdata = '0;
        mem.wvalid = 1'b0;
        mem.wlast = 1'b0;
        mem.rready = 1'b0;
        m0.gnt_ack = 1'b0;
        m0.wready = 1'b0;
        m0.rvalid = 1'b0;
        m1.gnt_ack = 1'b0;
        m1.wready = 1'b0;
        m1.rvalid = 1'b0;
        if (locked && !owner) begin
            mem.req = m0.req;
            mem.we = m0.we;
            mem.addr = m0.addr;
            mem.wdata = m0.wdata;
            mem.wvalid = m0.wvalid;
            mem.wlast = m0.wlast;
            mem.rready = m0.rready;
            m0.gnt_ack = mem.gnt_ack;
            m0.wready = mem.wready;
            m0.rvalid = mem.rvalid;
        end else if (locked && owner) begin
            mem.req = m1.req;
            mem.we = m1.we;
            mem.addr = m1.addr;
            mem.wdata = m1.wdata;
            mem.wvalid = m1.wvalid;
            mem.wlast = m1.wlast;
            mem.rready = m1.rready;
            m1.gnt_ack = mem.gnt_ack;
            m1.wready = mem.wready;
            m1.rvalid = mem.rvalid;
        end
    end

endmodule

/* design/refill_reader.sv */
module refill_reader (
    input  logic               clk,
    input  logic               rstn,
    input  wb_pkg::line_addr_u rd_addr,
    input  logic               rd_valid,
    output logic               rd_ready,
    output wb_pkg::line_t      rsp_data,
    output logic               rsp_hit,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output wb_pkg::line_addr_u query_addr,
    input  wb_pkg::line_t      query_data,
    input  logic               query_hit,
    line_bus_if.master         bus
);

    localparam int BEAT_BITS = $clog2(wb_pkg::LINE_WORDS_MAX);
    localparam int WORD_BITS = $bits(wb_pkg::word_t);

    localparam logic [2:0] S_INIT = 3'd0;
    localparam logic [2:0] S_IDLE = 3'd1;
    localparam logic [2:0] S_ADDR = 3'd2;
    localparam logic [2:0] S_DATA = 3'd3;
    localparam logic [2:0] S_RSP  = 3'd4;

    logic [2:0]           state;
    logic [BEAT_BITS-1:0] beat;
    wb_pkg::line_addr_u   req_addr;
    wb_pkg::line_t        line_q;
    logic                 hit_q;
    logic                 accept;

    assign accept = rd_valid && rd_ready;
    // buffer is probed while the request is offered
    assign query_addr = rd_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_INIT;
            beat <= '0;
            hit_q <= 1'b0;
        end else begin
            case (state)
                S_INIT: state <= S_IDLE;
                S_IDLE: begin
                    if (accept) begin
                        hit_q <= query_hit;
                        state <= query_hit ? S_RSP : S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (bus.gnt_ack) begin
                        state <= S_DATA;
                        beat <= '0;
                    end
                end
                S_DATA: begin
                    if (bus.rvalid) begin
                        beat <= beat + 1'b1;
                        if (bus.rlast) begin
                            state <= S_RSP;
                        end
                    end
                end
                S_RSP: begin
                    if (rsp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= rd_addr;
            req_addr.f.offset <= '0;
            if (query_hit) begin
                line_q <= query_data;
            end
        end
        // assemble the miss line beat by beat
        if (state == S_DATA && bus.rvalid) begin
            line_q[beat*WORD_BITS +: WORD_BITS] <= bus.rdata;
        end
    end

    assign rd_ready = state == S_IDLE;
    assign rsp_valid = state == S_RSP;
    assign rsp_data = line_q;
    assign rsp_hit = hit_q;

    assign bus.req = state == S_ADDR;
    assign bus.we = 1'b0;
    assign bus.addr = req_addr;
    assign bus.wdata = '0;
    assign bus.wvalid = 1'b0;
    assign bus.wlast = 1'b0;
    assign bus.rready = state == S_DATA;

endmodule

/* design/write_buffer.sv */
module write_buffer #(
    parameter int DEPTH = 5
) (
    input  logic               clk,
    input  logic               rstn,
    input  wb_pkg::line_addr_u in_addr,
    input  wb_pkg::line_t      in_data,
    input  logic               in_valid,
    output logic               in_ready,
    input  wb_pkg::line_addr_u query_addr,
    output wb_pkg::line_t      query_data,
    output logic               query_hit,
    line_bus_if.master         bus
);

    localparam int CW = $clog2(DEPTH + 1);
    localparam int BEAT_BITS = $clog2(wb_pkg::LINE_WORDS_MAX);
    localparam int WORD_BITS = $bits(wb_pkg::word_t);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;

    wb_pkg::line_addr_u addr_q [DEPTH];
    wb_pkg::line_t      data_q [DEPTH];

    logic [CW-1:0]        count;
    logic [CW-1:0]        count_nxt;
    logic [CW-1:0]        oldest;
    logic [1:0]           state;
    logic [BEAT_BITS-1:0] beat;
    wb_pkg::line_addr_u   drain_addr;
    wb_pkg::line_t        drain_line;
    logic                 push;
    logic                 drop;

    assign push = in_valid && in_ready;
    // entry goes once its last beat is taken
    assign drop = bus.wvalid && bus.wready && bus.wlast;
    // pushes shift everything up, so the oldest is always at count-1
    assign oldest = count - 1'b1;

    always_comb begin
        count_nxt = count;
        if (push && !drop) begin
            count_nxt = count + 1'b1;
        end else if (drop && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            in_ready <= 1'b0;
        end else begin
            count <= count_nxt;
            in_ready <= count_nxt < CW'(DEPTH);
        end
    end

    // shift queue, entry 0 newest
    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[0] <= in_addr;
            data_q[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
                data_q[i] <= data_q[i-1];
            end
        end
    end

    // newest valid match wins
    always_comb begin
        query_hit = 1'b0;
        query_data = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i < int'(count) && addr_q[i].raw == query_addr.raw) begin
                query_hit = 1'b1;
                query_data = data_q[i];
            end
        end
    end

    // drain fsm
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
            beat <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (count != '0) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (bus.gnt_ack) begin
                        state <= S_DATA;
                        beat <= '0;
                    end
                end
                S_DATA: begin
                    if (bus.wready) begin
                        beat <= beat + 1'b1;
                        if (bus.wlast) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // snapshot of the oldest entry for the burst
    always_ff @(posedge clk) begin
        if (state == S_IDLE && count != '0) begin
            drain_addr <= addr_q[oldest];
            drain_addr.f.offset <= '0;
            drain_line <= data_q[oldest];
        end
    end

    assign bus.req = state == S_ADDR;
    assign bus.we = 1'b1;
    assign bus.addr = drain_addr;
    assign bus.wvalid = state == S_DATA;
    assign bus.wdata = drain_line[beat*WORD_BITS +: WORD_BITS];
    assign bus.wlast = beat == BEAT_BITS'(wb_pkg::LINE_WORDS_MAX - 1);
    assign bus.rready = 1'b0;

endmodule

/* design/line_bus_if.sv */
interface line_bus_if;

    // address phase
    logic req;
    logic we;
    wb_pkg::line_addr_u addr;
    logic gnt_ack;

    // write beats
    wb_pkg::word_t wdata;
    logic wvalid;
    logic wlast;
    logic wready;

    // read beats
    wb_pkg::word_t rdata;
    logic rvalid;
    logic rlast;
    logic rready;

    modport master (
        output req, we, addr, wdata, wvalid, wlast, rready,
        input  gnt_ack, wready, rdata, rvalid, rlast
    );

    modport slave (
        input  req, we, addr, wdata, wvalid, wlast, rready,
        output gnt_ack, wready, rdata, rvalid, rlast
    );

endinterface

/* design/wb_pkg.sv */
package wb_pkg;

    localparam int LINE_WORDS_MAX = 8;
    localparam int OFFSET_BITS = 5;
    // wide enough for any MEM_LINES the memory is built with
    localparam int INDEX_BITS = 8;
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits and goes out first
    typedef logic [LINE_WORDS_MAX*32-1:0] line_t;

    // raw view for whole-word compare, field view for line decode
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_BITS-1:0] tag;
            logic [INDEX_BITS-1:0] index;
            logic [OFFSET_BITS-1:0] offset;
        } f;
    } line_addr_u;

endpackage
